// File: Makefile
# Verilator build and run of the fetch front-end testbench.

VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check for the pass message"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// File: fetch_assert.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_assert (
  input logic              clock,
  input logic              reset,
  input logic              redirect_valid,
  input logic              fetch_valid,
  input logic              buf_valid,
  input logic              instr_valid,
  input logic              instr_ready,
  input fetch_pkg::addr_t  instr_pc,
  input fetch_pkg::instr_t instr_data
);

  // Every valid in the pipeline starts low once reset has been seen.
  instr_valid_reset: assert property (@(posedge clock) !reset |=> !instr_valid)
    else $error("instr_valid is high right after reset");

  fetch_valid_reset: assert property (@(posedge clock) !reset |=> !fetch_valid)
    else $error("fetch_valid is high right after reset");

  buf_valid_reset: assert property (@(posedge clock) !reset |=> !buf_valid)
    else $error("buf_valid is high right after reset");

  // A stalled output holds still. A redirect may withdraw it.
  output_stable: assert property (@(posedge clock) disable iff (!reset)
    instr_valid && !instr_ready && !redirect_valid
    |=> instr_valid && $stable(instr_pc) && $stable(instr_data))
    else $error("instr output changed while stalled");

endmodule

bind fetch_top fetch_assert u_fetch_assert (
  .clock          (clock),
  .reset          (reset),
  .redirect_valid (redirect_valid),
  .fetch_valid    (fetch_valid),
  .buf_valid      (buf_valid),
  .instr_valid    (instr_valid),
  .instr_ready    (instr_ready),
  .instr_pc       (instr_pc),
  .instr_data     (instr_data)
);

`default_nettype wire

// File: fetch_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_buffer #(
  parameter int DEPTH = `FETCH_BUF_DEPTH
) (
  input  logic              clock,
  input  logic              reset,
  input  logic              flush,
  input  logic              fetch_valid,
  output logic              fetch_ready,
  input  fetch_pkg::addr_t   fetch_pc,
  input  fetch_pkg::bundle_t fetch_data,
  output logic              buf_valid,
  input  logic              buf_ready,
  output fetch_pkg::addr_t   buf_pc,
  output fetch_pkg::bundle_t buf_data
);
  import fetch_pkg::*;

  localparam int ptr_w   = $clog2(DEPTH);
  localparam int count_w = $clog2(DEPTH + 1);

  addr_t   pc_mem   [DEPTH];
  bundle_t data_mem [DEPTH];

  logic [ptr_w-1:0]   wr_ptr;
  logic [ptr_w-1:0]   rd_ptr;
  logic [count_w-1:0] count;

  logic full;
  logic push;
  logic pop;

  // Pointers wrap at DEPTH so any depth works, not only powers of two.
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full        = (count == count_w'(DEPTH));
  assign buf_valid   = (count != '0);
  assign fetch_ready = !full || buf_ready; // A full buffer still takes a bundle while one leaves.
  assign push        = fetch_valid && fetch_ready;
  assign pop         = buf_valid && buf_ready;

  always_ff @(posedge clock) begin
    if ((reset == 1'b0) || flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      pc_mem[wr_ptr]   <= fetch_pc;
      data_mem[wr_ptr] <= fetch_data;
    end
  end

  assign buf_pc   = pc_mem[rd_ptr];
  assign buf_data = data_mem[rd_ptr];

endmodule

`default_nettype wire

// File: fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Address of the first bundle fetched after reset.
`define RESET_PC 32'h0000_0000

// Number of 64-bit words in the instruction memory.
// Fetch addresses wrap modulo eight times this size.
`define ITIM_WORDS 64

// Default number of pc/bundle entries in the fetch buffer.
`define FETCH_BUF_DEPTH 4

`endif

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // Byte address of an instruction or bundle.
  typedef logic [31:0] addr_t;

  // One RISC-V instruction word.
  typedef logic [31:0] instr_t;

  // Two instructions fetched together from one aligned doubleword.
  // The lo field holds the instruction at the lower address.
  typedef struct packed {
    instr_t hi;
    instr_t lo;
  } bundle_t;

endpackage

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage (
  input  logic              clock,
  input  logic              reset,
  input  logic              redirect_valid,
  input  fetch_pkg::addr_t   redirect_pc,
  output logic              mem_valid,
  output fetch_pkg::addr_t   mem_addr,
  input  logic              mem_ready,
  input  fetch_pkg::bundle_t mem_rdata,
  output logic              fetch_valid,
  output fetch_pkg::addr_t   fetch_pc,
  output fetch_pkg::bundle_t fetch_data,
  input  logic              fetch_ready
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    idle,
    busy,
    jump
  } state_t;

  state_t state;
  state_t next_state;

  addr_t   pc;          // Address of the next request.
  logic    inflight;
  addr_t   inflight_pc;
  logic    resp_seen;   // Response returned but still parked in the memory read register.
  logic    hold_valid;
  addr_t   hold_pc;
  bundle_t hold_data;

  logic handover;
  logic hold_free;
  logic capture;
  logic park;
  logic issue;

  assign handover  = hold_valid && fetch_ready;
  assign hold_free = !hold_valid || handover;

  // At most one request is in flight and one bundle is held.
  // A new request may go out only once the in-flight one has landed.
  always_comb begin
    next_state = state;
    capture    = 1'b0;
    park       = 1'b0;
    issue      = 1'b0;
    case (state)
      idle: begin
        next_state = busy;
      end
      busy: begin
        capture = inflight && (mem_ready || resp_seen) && hold_free;
        park    = inflight && mem_ready && !hold_free;
        issue   = !inflight || capture;
      end
      jump: begin
        issue      = !inflight; // The response in this cycle is stale and is ignored.
        next_state = busy;
      end
      default: begin
        next_state = idle;
      end
    endcase
    if (redirect_valid) begin
      next_state = issue ? jump : busy;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state      <= idle;
      pc         <= `RESET_PC;
      inflight   <= 1'b0;
      resp_seen  <= 1'b0;
      hold_valid <= 1'b0;
    end else if (redirect_valid) begin
      state      <= next_state;
      pc         <= {redirect_pc[31:3], 3'b000};
      inflight   <= 1'b0;
      resp_seen  <= 1'b0;
      hold_valid <= 1'b0;
    end else begin
      state <= next_state;
      if (issue) begin
        pc       <= pc + addr_t'(8);
        inflight <= 1'b1;
      end
      if (capture) begin
        resp_seen <= 1'b0;
      end else if (park) begin
        resp_seen <= 1'b1;
      end
      if (capture) begin
        hold_valid <= 1'b1;
      end else if (handover) begin
        hold_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      inflight_pc <= pc;
    end
    if (capture) begin
      hold_pc   <= inflight_pc;
      hold_data <= mem_rdata;
    end
  end

  assign mem_valid   = issue;
  assign mem_addr    = pc;
  assign fetch_valid = hold_valid;
  assign fetch_pc    = hold_pc;
  assign fetch_data  = hold_data;

endmodule

`default_nettype wire

// File: fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam int index_w = $clog2(`ITIM_WORDS);
  localparam int stream_timeout = 400;

  typedef logic [index_w-1:0] index_t;

  logic    clock;
  logic    reset;
  logic    load_valid;
  addr_t   load_addr;
  bundle_t load_data;
  logic    redirect_valid;
  addr_t   redirect_pc;
  logic    instr_valid;
  logic    instr_ready;
  addr_t   instr_pc;
  instr_t  instr_data;

  bundle_t ref_mem [`ITIM_WORDS]; // Same contents as the DUT memory.
  int      error_count;
  int      test_count;

  fetch_top u_dut (
    .clock          (clock),
    .reset          (reset),
    .load_valid     (load_valid),
    .load_addr      (load_addr),
    .load_data      (load_data),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .instr_valid    (instr_valid),
    .instr_ready    (instr_ready),
    .instr_pc       (instr_pc),
    .instr_data     (instr_data)
  );

  always #4 clock = ~clock;

  // Inputs change 1 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  function automatic instr_t expected_instr(input addr_t addr);
    bundle_t word;
    word = ref_mem[index_t'((addr >> 3) % `ITIM_WORDS)];
    return addr[2] ? word.hi : word.lo; // Bit 2 picks the upper instruction.
  endfunction

  task automatic compare_pc(input addr_t got, input addr_t expected);
    if (got !== expected) begin
      $display("FAILED instr_pc: got %h, expected %h", got, expected);
      error_count++;
    end
  endtask

  task automatic compare_instr(input instr_t got, input instr_t expected);
    if (got !== expected) begin
      $display("FAILED instr_data: got %h, expected %h", got, expected);
      error_count++;
    end
  endtask

  // Fills the memory with random words while reset is held.
  task automatic load_memory();
    bundle_t word;
    for (int i = 0; i < `ITIM_WORDS; i++) begin
      word.hi = $urandom();
      word.lo = $urandom();
      ref_mem[index_t'(i)] = word;
      load_valid = 1'b1;
      load_addr  = addr_t'(i * 8);
      load_data  = word;
      next_cycle();
    end
    load_valid = 1'b0;
  endtask

  task automatic apply_reset();
    instr_ready = 1'b0;
    reset = 1'b0;
    repeat (5) next_cycle();
    reset = 1'b1;
  endtask

  task automatic send_redirect(input addr_t target);
    redirect_valid = 1'b1;
    redirect_pc    = target;
    next_cycle();
    redirect_valid = 1'b0;
  endtask

  // Accepts count instructions and checks them against the sequence from start_pc.
  task automatic stream_check(input addr_t start_pc, input int count, input logic random_ready);
    addr_t       expect_pc;
    int          accepted;
    int          cycles;
    logic [31:0] rnd;
    expect_pc = start_pc;
    accepted  = 0;
    cycles    = 0;
    while ((accepted < count) && (cycles < stream_timeout)) begin
      rnd = $urandom();
      instr_ready = random_ready ? rnd[0] : 1'b1;
      #1;
      if (instr_valid && instr_ready) begin
        compare_pc(instr_pc, expect_pc);
        compare_instr(instr_data, expected_instr(expect_pc));
        expect_pc = expect_pc + addr_t'(4);
        accepted++;
      end
      next_cycle();
      cycles++;
    end
    instr_ready = 1'b0;
    if (accepted < count) begin
      $display("Timeout: only %0d of %0d instructions arrived in %0d cycles.",
               accepted, count, stream_timeout);
      error_count++;
    end
  endtask

  task automatic report_result(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("test %0d, %s: ok", test_count, name);
    end else begin
      $display("test %0d, %s: %0d errors", test_count, name, error_count - errors_before);
    end
  endtask

  task automatic sequential_stream();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    stream_check(`RESET_PC, 40, 1'b0);
    report_result("sequential stream", errors_before);
  endtask

  task automatic backpressure_stream();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    stream_check(`RESET_PC, 40, 1'b1);
    report_result("random back-pressure", errors_before);
  endtask

  task automatic even_redirect();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    stream_check(`RESET_PC, 10, 1'b0);
    send_redirect(32'h0000_0098);
    stream_check(32'h0000_0098, 16, 1'b0);
    report_result("redirect to even word", errors_before);
  endtask

  task automatic odd_redirect();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    stream_check(`RESET_PC, 7, 1'b1);
    send_redirect(32'h0000_0054); // The stream resumes at the upper half.
    stream_check(32'h0000_0054, 12, 1'b0);
    report_result("redirect to odd word", errors_before);
  endtask

  task automatic wrap_around();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    stream_check(`RESET_PC, 4, 1'b0);
    send_redirect(addr_t'((`ITIM_WORDS - 1) * 8));
    stream_check(addr_t'((`ITIM_WORDS - 1) * 8), 12, 1'b0);
    report_result("wrap-around", errors_before);
  endtask

  task automatic stall_redirect();
    int errors_before;
    errors_before = error_count;
    apply_reset();
    stream_check(`RESET_PC, 6, 1'b0);
    repeat (20) next_cycle(); // Buffer and holding register fill up meanwhile.
    send_redirect(32'h0000_00e0);
    stream_check(32'h0000_00e0, 16, 1'b1);
    report_result("redirect under stall", errors_before);
  endtask

  initial begin
    clock          = 1'b0;
    reset          = 1'b0;
    load_valid     = 1'b0;
    load_addr      = '0;
    load_data      = '0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    instr_ready    = 1'b0;
    error_count    = 0;
    test_count     = 0;
    void'($urandom(32'h0f69_fe6b));
    next_cycle();
    load_memory();
    sequential_stream();
    backpressure_stream();
    even_redirect();
    odd_redirect();
    wrap_around();
    stall_redirect();
    $display("%0d tests run, %0d errors", test_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_top (
  input  logic              clock,
  input  logic              reset,
  input  logic              load_valid,
  input  fetch_pkg::addr_t   load_addr,
  input  fetch_pkg::bundle_t load_data,
  input  logic              redirect_valid,
  input  fetch_pkg::addr_t   redirect_pc,
  output logic              instr_valid,
  input  logic              instr_ready,
  output fetch_pkg::addr_t   instr_pc,
  output fetch_pkg::instr_t  instr_data
);
  import fetch_pkg::*;

  logic    mem_valid;
  addr_t   mem_addr;
  logic    mem_ready;
  bundle_t mem_rdata;

  logic    fetch_valid;
  logic    fetch_ready;
  addr_t   fetch_pc;
  bundle_t fetch_data;

  logic    buf_valid;
  logic    buf_ready;
  addr_t   buf_pc;
  bundle_t buf_data;

  itim u_itim (
    .clock      (clock),
    .reset      (reset),
    .load_valid (load_valid),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .mem_valid  (mem_valid),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_rdata  (mem_rdata)
  );

  fetch_stage u_fetch_stage (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mem_valid      (mem_valid),
    .mem_addr       (mem_addr),
    .mem_ready      (mem_ready),
    .mem_rdata      (mem_rdata),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_data     (fetch_data),
    .fetch_ready    (fetch_ready)
  );

  // The redirect pulse also empties the buffer and restarts the unpacker.
  fetch_buffer u_fetch_buffer (
    .clock       (clock),
    .reset       (reset),
    .flush       (redirect_valid),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch_pc    (fetch_pc),
    .fetch_data  (fetch_data),
    .buf_valid   (buf_valid),
    .buf_ready   (buf_ready),
    .buf_pc      (buf_pc),
    .buf_data    (buf_data)
  );

  instr_unpack u_instr_unpack (
    .clock       (clock),
    .reset       (reset),
    .flush       (redirect_valid),
    .flush_pc    (redirect_pc),
    .buf_valid   (buf_valid),
    .buf_ready   (buf_ready),
    .buf_pc      (buf_pc),
    .buf_data    (buf_data),
    .instr_valid (instr_valid),
    .instr_ready (instr_ready),
    .instr_pc    (instr_pc),
    .instr_data  (instr_data)
  );

endmodule

`default_nettype wire

// File: instr_unpack.sv
`timescale 1ns/1ns
`default_nettype none

module instr_unpack (
  input  logic              clock,
  input  logic              reset,
  input  logic              flush,
  input  fetch_pkg::addr_t   flush_pc,
  input  logic              buf_valid,
  output logic              buf_ready,
  input  fetch_pkg::addr_t   buf_pc,
  input  fetch_pkg::bundle_t buf_data,
  output logic              instr_valid,
  input  logic              instr_ready,
  output fetch_pkg::addr_t   instr_pc,
  output fetch_pkg::instr_t  instr_data
);
  import fetch_pkg::*;

  logic upper;     // The lower instruction of the current bundle has been sent.
  logic skip_low;  // The redirect target is the upper instruction of the next bundle.
  logic sel_upper;
  logic accept;

  assign sel_upper = upper || skip_low;
  assign accept    = instr_valid && instr_ready;

  assign instr_valid = buf_valid;
  assign instr_pc    = sel_upper ? buf_pc + addr_t'(4) : buf_pc;
  assign instr_data  = sel_upper ? buf_data.hi : buf_data.lo;

  // The bundle leaves the buffer together with its upper instruction.
  assign buf_ready = sel_upper && instr_ready;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      upper    <= 1'b0;
      skip_low <= 1'b0;
    end else if (flush) begin
      upper    <= 1'b0;
      skip_low <= flush_pc[2];
    end else if (accept) begin
      if (sel_upper) begin
        upper    <= 1'b0;
        skip_low <= 1'b0;
      end else begin
        upper <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: itim.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module itim (
  input  logic              clock,
  input  logic              reset,
  input  logic              load_valid,
  input  fetch_pkg::addr_t   load_addr,
  input  fetch_pkg::bundle_t load_data,
  input  logic              mem_valid,
  input  fetch_pkg::addr_t   mem_addr,
  output logic              mem_ready,
  output fetch_pkg::bundle_t mem_rdata
);
  import fetch_pkg::*;

  localparam int index_w = $clog2(`ITIM_WORDS);

  bundle_t mem [`ITIM_WORDS];

  logic [index_w-1:0] load_index;
  logic [index_w-1:0] read_index;

  // Bits 2:0 select bytes inside a bundle. Higher bits beyond the array wrap.
  assign load_index = load_addr[index_w+2:3];
  assign read_index = mem_addr[index_w+2:3];

  always_ff @(posedge clock) begin
    if (load_valid) begin
      mem[load_index] <= load_data;
    end
  end

  // The read register keeps its value until the next request.
  always_ff @(posedge clock) begin
    if (mem_valid) begin
      mem_rdata <= mem[read_index];
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      mem_ready <= 1'b0;
    end else begin
      mem_ready <= mem_valid; // Every request is answered one cycle later.
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
fetch_pkg.sv
itim.sv
fetch_stage.sv
fetch_buffer.sv
instr_unpack.sv
fetch_top.sv
fetch_assert.sv
fetch_tb.sv
